// ==== src/conspiracion_pkg.sv ====
package conspiracion_pkg;

	// ====================
	// Address map
	// ====================

	// Word address bits 29:8 select the peripheral window.
	localparam logic [21:0] PERIPH_BASE = 22'h30_0000;

	// Device codes in word address bits 7:4.
	localparam logic [3:0] DEV_PIO   = 4'h0;
	localparam logic [3:0] DEV_TIMER = 4'h1;

	// PIO register indices.
	localparam logic [3:0] PIO_LEDS     = 4'd0;
	localparam logic [3:0] PIO_SWITCHES = 4'd1;
	localparam logic [3:0] PIO_BUTTONS  = 4'd2;
	localparam logic [3:0] PIO_EDGE     = 4'd3;
	localparam logic [3:0] PIO_IRQ_MASK = 4'd4;

	// Interval timer register indices.
	localparam logic [3:0] TMR_LOAD   = 4'd0;
	localparam logic [3:0] TMR_COUNT  = 4'd1;
	localparam logic [3:0] TMR_CTRL   = 4'd2;
	localparam logic [3:0] TMR_STATUS = 4'd3;

	// Read data for anything outside the map.
	localparam logic [31:0] BUS_ERR_WORD = 32'hdead_beef;

	// Stable samples needed before a debouncer moves.
	localparam int unsigned DEBOUNCE_CYCLES = 16;

	// ====================
	// Bus types
	// ====================

	typedef struct packed {
		logic [29:0] addr;
		logic [31:0] data_wr;
		logic [3:0]  be;
		logic        write;
	} bus_req_t;

	typedef struct packed {
		logic [3:0]  reg_idx;
		logic [31:0] wdata;
		logic [3:0]  be;
		logic        write;
	} dev_req_t;

endpackage

// ==== src/debounce.sv ====
module debounce import conspiracion_pkg::*;
#(
	parameter logic IDLE = 1'b0
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic dirty,
	output logic clean
);

	logic meta, sync_q;
	logic [$clog2(DEBOUNCE_CYCLES)-1:0] cnt;
	logic full;

	assign full = cnt == $bits(cnt)'(DEBOUNCE_CYCLES - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			meta <= IDLE;
			sync_q <= IDLE;
			clean <= IDLE;
			cnt <= '0;
		end else begin
			meta <= dirty;
			sync_q <= meta;

			// Any sample matching the output restarts the count.
			if (sync_q == clean)
				cnt <= '0;
			else if (full) begin
				clean <= sync_q;
				cnt <= '0;
			end else
				cnt <= cnt + 1'b1;
		end
	end

	// Output moves only after a full run of differing samples.
	assert property (@(posedge clk) disable iff (!rst_n)
		clean != $past(clean) |-> $past(full) && $past(sync_q) == clean);

endmodule

// ==== src/pio_ctrl.sv ====
module pio_ctrl import conspiracion_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        sel,
	input  dev_req_t    req,
	input  logic [5:0]  switches,
	input  logic        button_n,
	output logic [31:0] rdata,
	output logic [7:0]  leds,
	output logic        irq
);

	logic pressed, pressed_q, press;
	logic edge_q, irq_mask;
	logic wr, edge_clr;

	// Button is active low.
	assign pressed = !button_n;
	assign press = pressed && !pressed_q;

	assign wr = sel && req.write;
	assign edge_clr = wr && req.reg_idx == PIO_EDGE && req.be[0] && req.wdata[0];

	// ====================
	// Registers
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			leds <= '0;
			irq_mask <= 1'b0;
			edge_q <= 1'b0;
			pressed_q <= 1'b0;
		end else begin
			pressed_q <= pressed;

			if (wr && req.reg_idx == PIO_LEDS && req.be[0])
				leds <= req.wdata[7:0];

			if (wr && req.reg_idx == PIO_IRQ_MASK && req.be[0])
				irq_mask <= req.wdata[0];

			// A new press beats a clear in the same cycle.
			if (press)
				edge_q <= 1'b1;
			else if (edge_clr)
				edge_q <= 1'b0;
		end
	end

	// ====================
	// Read mux
	// ====================

	always_comb begin
		unique case (req.reg_idx)
			PIO_LEDS:     rdata = {24'd0, leds};
			PIO_SWITCHES: rdata = {26'd0, switches};
			PIO_BUTTONS:  rdata = {31'd0, pressed};
			PIO_EDGE:     rdata = {31'd0, edge_q};
			PIO_IRQ_MASK: rdata = {31'd0, irq_mask};
			default:      rdata = '0;
		endcase
	end

	assign irq = edge_q && irq_mask;

	// The edge bit only sets on a captured press.
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(edge_q) |-> $past(press));

endmodule

// ==== src/interval_timer.sv ====
module interval_timer import conspiracion_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        sel,
	input  dev_req_t    req,
	output logic [31:0] rdata,
	output logic        irq
);

	logic [31:0] load_q, count_q;
	logic enable, irq_en, expired;
	logic wr, load_wr, ctrl_wr, status_clr, wrap;

	assign wr = sel && req.write;
	assign load_wr = wr && req.reg_idx == TMR_LOAD;
	assign ctrl_wr = wr && req.reg_idx == TMR_CTRL && req.be[0];
	assign status_clr = wr && req.reg_idx == TMR_STATUS && req.be[0] && req.wdata[0];

	assign wrap = enable && count_q == '0;

	// ====================
	// Registers
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_q <= '0;
			count_q <= '0;
			enable <= 1'b0;
			irq_en <= 1'b0;
			expired <= 1'b0;
		end else begin
			if (load_wr)
				for (int i = 0; i < 4; i++)
					if (req.be[i])
						load_q[i*8 +: 8] <= req.wdata[i*8 +: 8];

			if (ctrl_wr) begin
				enable <= req.wdata[0];
				irq_en <= req.wdata[1];
			end

			// Starting the timer restarts the count from LOAD.
			if (ctrl_wr && req.wdata[0])
				count_q <= load_q;
			else if (wrap)
				count_q <= load_q;
			else if (enable)
				count_q <= count_q - 1'b1;

			if (wrap)
				expired <= 1'b1;
			else if (status_clr)
				expired <= 1'b0;
		end
	end

	always_comb begin
		unique case (req.reg_idx)
			TMR_LOAD:   rdata = load_q;
			TMR_COUNT:  rdata = count_q;
			TMR_CTRL:   rdata = {30'd0, irq_en, enable};
			TMR_STATUS: rdata = {31'd0, expired};
			default:    rdata = '0;
		endcase
	end

	assign irq = expired && irq_en;

	// A stopped timer holds its count.
	assert property (@(posedge clk) disable iff (!rst_n)
		!enable && !ctrl_wr |=> count_q == $past(count_q));

endmodule

// ==== src/bus_fabric.sv ====
module bus_fabric import conspiracion_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  bus_req_t    req,
	input  logic [31:0] pio_rdata,
	input  logic [31:0] tmr_rdata,
	input  logic        pio_irq,
	input  logic        tmr_irq,
	output logic [31:0] data_rd,
	output logic        ready,
	output logic        pio_sel,
	output logic        tmr_sel,
	output dev_req_t    dev_req,
	output logic        irq
);

	logic in_window;
	logic [3:0] dev;
	logic [31:0] rdata_next;

	// ====================
	// Address decode
	// ====================

	assign in_window = req.addr[29:8] == PERIPH_BASE;
	assign dev = req.addr[7:4];

	assign pio_sel = start && in_window && dev == DEV_PIO;
	assign tmr_sel = start && in_window && dev == DEV_TIMER;

	// Both devices see the same request and sel picks the one that acts.
	assign dev_req.reg_idx = req.addr[3:0];
	assign dev_req.wdata = req.data_wr;
	assign dev_req.be = req.be;
	assign dev_req.write = req.write;

	always_comb begin
		if (pio_sel)
			rdata_next = pio_rdata;
		else if (tmr_sel)
			rdata_next = tmr_rdata;
		else
			rdata_next = BUS_ERR_WORD;
	end

	// ====================
	// Response
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready <= 1'b0;
			data_rd <= '0;
		end else begin
			ready <= start;
			if (start)
				data_rd <= rdata_next;
		end
	end

	assign irq = pio_irq || tmr_irq;

	// Master waits for ready before the next request.
	assert property (@(posedge clk) disable iff (!rst_n)
		start |=> !start);

	// Writes must enable some lane.
	assert property (@(posedge clk) disable iff (!rst_n)
		start && req.write |-> req.be != 4'b0000);

endmodule

// ==== src/conspiracion_platform.sv ====
module conspiracion_platform import conspiracion_pkg::*;
(
	input  logic        clk_clk,
	input  logic        rst_n,
	input  logic        halt,
	input  logic        pio_buttons,
	input  logic [5:0]  pio_switches,
	input  logic [29:0] bus_addr,
	input  logic [31:0] bus_data_wr,
	input  logic [3:0]  bus_data_be,
	input  logic        bus_write,
	input  logic        bus_start,
	output logic [31:0] bus_data_rd,
	output logic        bus_ready,
	output logic        irq,
	output logic        cpu_halt,
	output logic [7:0]  pio_leds
);

	bus_req_t bus_req;
	dev_req_t dev_req;
	logic button;
	logic pio_sel, tmr_sel, pio_irq, tmr_irq;
	logic [31:0] pio_rdata, tmr_rdata;

	assign bus_req.addr = bus_addr;
	assign bus_req.data_wr = bus_data_wr;
	assign bus_req.be = bus_data_be;
	assign bus_req.write = bus_write;

	// Idle levels are not halted and button released (high).
	debounce #(.IDLE(1'b0)) halt_debounce
	(
		.clk(clk_clk),
		.rst_n(rst_n),
		.dirty(halt),
		.clean(cpu_halt)
	);

	debounce #(.IDLE(1'b1)) button_debounce
	(
		.clk(clk_clk),
		.rst_n(rst_n),
		.dirty(pio_buttons),
		.clean(button)
	);

	bus_fabric fabric
	(
		.clk(clk_clk),
		.rst_n(rst_n),
		.start(bus_start),
		.req(bus_req),
		.pio_rdata(pio_rdata),
		.tmr_rdata(tmr_rdata),
		.pio_irq(pio_irq),
		.tmr_irq(tmr_irq),
		.data_rd(bus_data_rd),
		.ready(bus_ready),
		.pio_sel(pio_sel),
		.tmr_sel(tmr_sel),
		.dev_req(dev_req),
		.irq(irq)
	);

	pio_ctrl pio
	(
		.clk(clk_clk),
		.rst_n(rst_n),
		.sel(pio_sel),
		.req(dev_req),
		.switches(pio_switches),
		.button_n(button),
		.rdata(pio_rdata),
		.leds(pio_leds),
		.irq(pio_irq)
	);

	interval_timer timer
	(
		.clk(clk_clk),
		.rst_n(rst_n),
		.sel(tmr_sel),
		.req(dev_req),
		.rdata(tmr_rdata),
		.irq(tmr_irq)
	);

endmodule

// ==== verif/platform_checker.sv ====
module platform_checker import conspiracion_pkg::*;
(
	input logic        clk,
	input logic        rst_n,
	input bus_req_t    req,
	input logic        bus_start,
	input logic        bus_ready,
	input logic [31:0] bus_data_rd,
	input logic [5:0]  pio_switches,
	input logic [7:0]  pio_leds
);

	string test_name = "reset";
	int checks = 0;
	int errors = 0;
	int test_errors = 0;
	int tests = 0;
	int failed_tests = 0;

	logic [7:0] leds_sh;
	logic [1:0] ctrl_sh;
	logic [31:0] load_sh, expected_q;
	logic mask_sh, start_q, modeled_q, in_window;

	assign in_window = req.addr[29:8] == PERIPH_BASE;

	// Expected read word from the shadow registers and the switch inputs.
	function automatic logic [31:0] expected_read(input logic [29:0] addr);
		if (addr[29:8] == PERIPH_BASE && addr[7:4] == DEV_PIO)
			case (addr[3:0])
				PIO_LEDS:     return {24'd0, leds_sh};
				PIO_SWITCHES: return {26'd0, pio_switches};
				PIO_IRQ_MASK: return {31'd0, mask_sh};
				default:      return '0;
			endcase
		if (addr[29:8] == PERIPH_BASE && addr[7:4] == DEV_TIMER)
			case (addr[3:0])
				TMR_LOAD: return load_sh;
				TMR_CTRL: return {30'd0, ctrl_sh};
				default:  return '0;
			endcase
		return BUS_ERR_WORD;
	endfunction

	// Buttons, edge, count and status follow live state and are checked by the tests.
	function automatic logic modeled(input logic [29:0] addr);
		if (addr[29:8] != PERIPH_BASE)
			return 1'b1;
		if (addr[7:4] == DEV_PIO)
			return addr[3:0] != PIO_BUTTONS && addr[3:0] != PIO_EDGE;
		if (addr[7:4] == DEV_TIMER)
			return addr[3:0] != TMR_COUNT && addr[3:0] != TMR_STATUS;
		return 1'b1;
	endfunction

	task automatic compare(input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			test_errors++;
			$display("MISMATCH %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic check_at_most(input logic [31:0] limit, input logic [31:0] actual);
		checks++;
		if (actual > limit) begin
			errors++;
			test_errors++;
			$display("MISMATCH %s: expected <= %h, actual %h", test_name, limit, actual);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		test_errors++;
		$display("%s: %s", test_name, what);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests++;
		if (test_errors != 0)
			failed_tests++;
		$display("%-18s %s, %0d errors", test_name, test_errors == 0 ? "ok" : "failed", test_errors);
	endtask

	// ====================
	// Shadow registers
	// ====================

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			leds_sh <= '0;
			mask_sh <= 1'b0;
			load_sh <= '0;
			ctrl_sh <= '0;
			start_q <= 1'b0;
			modeled_q <= 1'b0;
			expected_q <= '0;
		end else begin
			start_q <= bus_start;
			if (bus_start) begin
				expected_q <= expected_read(req.addr);
				modeled_q <= !req.write && modeled(req.addr);
			end
			if (bus_start && req.write && in_window && req.addr[7:4] == DEV_PIO && req.be[0]) begin
				if (req.addr[3:0] == PIO_LEDS)
					leds_sh <= req.data_wr[7:0];
				if (req.addr[3:0] == PIO_IRQ_MASK)
					mask_sh <= req.data_wr[0];
			end
			if (bus_start && req.write && in_window && req.addr[7:4] == DEV_TIMER) begin
				if (req.addr[3:0] == TMR_LOAD)
					for (int i = 0; i < 4; i++)
						if (req.be[i])
							load_sh[i*8 +: 8] <= req.data_wr[i*8 +: 8];
				if (req.addr[3:0] == TMR_CTRL && req.be[0])
					ctrl_sh <= req.data_wr[1:0];
			end
		end
	end

	// Outputs are settled at the falling edge.
	always @(negedge clk) begin
		if (rst_n) begin
			if (bus_ready !== start_q)
				report_failure("ready did not come exactly one cycle after start");
			else if (bus_ready && modeled_q)
				compare(expected_q, bus_data_rd);
			if (pio_leds !== leds_sh)
				compare({24'd0, leds_sh}, {24'd0, pio_leds});
		end
	end

endmodule

// ==== verif/platform_tb.sv ====
module platform_tb import conspiracion_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 6 * 2000;

	logic clk, rst_n, halt, pio_buttons;
	logic [5:0] pio_switches;
	bus_req_t req;
	logic bus_start, bus_ready, irq, cpu_halt;
	logic [31:0] bus_data_rd;
	logic [7:0] pio_leds;
	logic [15:0] lfsr = 16'd50;
	int cycles = 0;

	conspiracion_platform conspiracion_platform_inst
	(
		.*,
		.clk_clk(clk),
		.bus_addr(req.addr),
		.bus_data_wr(req.data_wr),
		.bus_data_be(req.be),
		.bus_write(req.write)
	);

	platform_checker chk (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cycles <= cycles + 1;

	initial begin
		wait (cycles >= TIMEOUT_CYCLES);
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ====================
	// Helpers
	// ====================

	// Fibonacci LFSR with taps 16, 14, 13 and 11 stepped once per bit.
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			bits = {bits[30:0], lfsr[0]};
		end
		return bits;
	endfunction

	function automatic logic [29:0] reg_addr(input logic [3:0] dev, input logic [3:0] idx);
		return {PERIPH_BASE, dev, idx};
	endfunction

	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic bus_access(input logic [29:0] addr, input logic [31:0] data,
			input logic [3:0] be, input logic write, output logic [31:0] rd);
		req = {addr, data, be, write};
		bus_start = 1'b1;
		step(1);
		bus_start = 1'b0;
		while (!bus_ready)
			step(1);
		rd = bus_data_rd;
		// Idle cycle so that start never repeats right after ready.
		step(1);
	endtask

	task automatic bus_write_word(input logic [29:0] addr, input logic [31:0] data,
			input logic [3:0] be);
		logic [31:0] discard;
		bus_access(addr, data, be, 1'b1, discard);
	endtask

	task automatic bus_read_word(input logic [29:0] addr, output logic [31:0] data);
		bus_access(addr, '0, 4'hf, 1'b0, data);
	endtask

	task automatic set_button(input logic level);
		pio_buttons = level;
		step(DEBOUNCE_CYCLES + 4);
	endtask

	// ====================
	// Tests
	// ====================

	initial begin
		logic [31:0] rd, first;
		logic [29:0] addr;
		logic [3:0] be;
		int len, n, t0, polls;

		rst_n = 1'b0;
		halt = 1'b0;
		pio_buttons = 1'b1;
		pio_switches = '0;
		req = '0;
		bus_start = 1'b0;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		step(1);

		chk.begin_test("bus_timing");
		for (int i = 0; i < 16; i++) begin
			bus_read_word(reg_addr(i[0] ? DEV_TIMER : DEV_PIO, 4'd0), rd);
			step(1 + take_bits(2));
		end
		chk.end_test();

		chk.begin_test("leds");
		for (int i = 0; i < 24; i++) begin
			be = take_bits(4);
			bus_write_word(reg_addr(DEV_PIO, PIO_LEDS), take_bits(32), be == '0 ? 4'h1 : be);
			bus_read_word(reg_addr(DEV_PIO, PIO_LEDS), rd);
		end
		chk.end_test();

		chk.begin_test("switches_unmapped");
		for (int i = 0; i < 8; i++) begin
			pio_switches = take_bits(6);
			bus_read_word(reg_addr(DEV_PIO, PIO_SWITCHES), rd);
		end
		bus_write_word(reg_addr(DEV_PIO, PIO_IRQ_MASK), 1, 4'h1);
		bus_write_word(reg_addr(DEV_TIMER, TMR_LOAD), 32'h0000_1234, 4'hf);
		for (int i = 0; i < 12; i++) begin
			// Even passes hit unused device codes and odd passes miss the window.
			if (i % 2 == 0)
				addr = {PERIPH_BASE, 4'd2 + 4'(take_bits(3)), 4'(take_bits(2))};
			else
				addr = {PERIPH_BASE ^ (22'(take_bits(22)) | 22'd1), 8'(take_bits(5))};
			bus_write_word(addr, take_bits(32), 4'hf);
			bus_read_word(addr, rd);
			bus_read_word(reg_addr(DEV_PIO, PIO_LEDS), rd);
			bus_read_word(reg_addr(DEV_PIO, PIO_IRQ_MASK), rd);
			bus_read_word(reg_addr(DEV_TIMER, TMR_LOAD), rd);
		end
		bus_write_word(reg_addr(DEV_PIO, PIO_IRQ_MASK), 0, 4'h1);
		chk.end_test();

		chk.begin_test("debounce");
		len = 1 + take_bits(4) % (DEBOUNCE_CYCLES - 1);
		halt = 1'b1;
		step(len);
		halt = 1'b0;
		repeat (DEBOUNCE_CYCLES + 4) begin
			chk.compare(0, cpu_halt);
			step(1);
		end
		halt = 1'b1;
		t0 = cycles;
		while (!cpu_halt && cycles - t0 < DEBOUNCE_CYCLES + 4)
			step(1);
		chk.compare(1, cpu_halt);
		halt = 1'b0;
		step(DEBOUNCE_CYCLES + 4);
		chk.compare(0, cpu_halt);
		pio_buttons = 1'b0;
		step(len);
		set_button(1'b1);
		bus_read_word(reg_addr(DEV_PIO, PIO_BUTTONS), rd);
		chk.compare(0, rd);
		bus_read_word(reg_addr(DEV_PIO, PIO_EDGE), rd);
		chk.compare(0, rd);
		pio_buttons = 1'b0;
		t0 = cycles;
		rd = '0;
		while (rd != 1 && cycles - t0 < DEBOUNCE_CYCLES + 4)
			bus_read_word(reg_addr(DEV_PIO, PIO_BUTTONS), rd);
		chk.compare(1, rd);
		bus_read_word(reg_addr(DEV_PIO, PIO_EDGE), rd);
		chk.compare(1, rd);
		set_button(1'b1);
		bus_write_word(reg_addr(DEV_PIO, PIO_EDGE), 1, 4'h1);
		chk.end_test();

		chk.begin_test("button_irq");
		bus_write_word(reg_addr(DEV_PIO, PIO_IRQ_MASK), 1, 4'h1);
		set_button(1'b0);
		chk.compare(1, irq);
		bus_write_word(reg_addr(DEV_PIO, PIO_EDGE), 1, 4'h1);
		chk.compare(0, irq);
		bus_read_word(reg_addr(DEV_PIO, PIO_EDGE), rd);
		chk.compare(0, rd);
		set_button(1'b1);
		bus_write_word(reg_addr(DEV_PIO, PIO_IRQ_MASK), 0, 4'h1);
		pio_buttons = 1'b0;
		repeat (DEBOUNCE_CYCLES + 8) begin
			chk.compare(0, irq);
			step(1);
		end
		set_button(1'b1);
		bus_write_word(reg_addr(DEV_PIO, PIO_EDGE), 1, 4'h1);
		chk.end_test();

		chk.begin_test("timer");
		n = 4 + take_bits(4);
		bus_write_word(reg_addr(DEV_TIMER, TMR_LOAD), n, 4'hf);
		bus_write_word(reg_addr(DEV_TIMER, TMR_CTRL), 3, 4'h1);
		for (int i = 0; i < 8; i++) begin
			bus_read_word(reg_addr(DEV_TIMER, TMR_COUNT), rd);
			chk.check_at_most(n, rd);
		end
		polls = 0;
		rd = '0;
		while (rd != 1 && polls < 100) begin
			bus_read_word(reg_addr(DEV_TIMER, TMR_STATUS), rd);
			polls++;
		end
		chk.compare(1, rd);
		chk.compare(1, irq);
		// Stop counting first so no new expiry races the clear.
		bus_write_word(reg_addr(DEV_TIMER, TMR_CTRL), 2, 4'h1);
		chk.compare(1, irq);
		bus_write_word(reg_addr(DEV_TIMER, TMR_STATUS), 1, 4'h1);
		chk.compare(0, irq);
		bus_read_word(reg_addr(DEV_TIMER, TMR_COUNT), first);
		bus_read_word(reg_addr(DEV_TIMER, TMR_COUNT), rd);
		chk.compare(first, rd);
		chk.end_test();

		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			chk.tests, chk.failed_tests, chk.checks, chk.errors);
		if (chk.errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
src/conspiracion_pkg.sv
src/debounce.sv
src/pio_ctrl.sv
src/interval_timer.sv
src/bus_fabric.sv
src/conspiracion_platform.sv
verif/platform_checker.sv
verif/platform_tb.sv

// ==== Bender.yml ====
package:
  name: conspiracion_platform

sources:
  - src/conspiracion_pkg.sv
  - src/debounce.sv
  - src/pio_ctrl.sv
  - src/interval_timer.sv
  - src/bus_fabric.sv
  - src/conspiracion_platform.sv
  - target: test
    files:
      - verif/platform_checker.sv
      - verif/platform_tb.sv
